//--- spi_link.f
source/spi_cfg_pkg.sv
source/spi_char_pkg.sv
source/spi_cfg_regs.sv
source/spi_master_engine.sv
source/spi_slave_engine.sv
source/spi_link_top.sv
tb/tb_clock_gen.sv
tb/spi_link_asserts.sv
tb/spi_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the spi link testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f spi_link.f --top-module spi_link_tb -o spi_link_sim \
    && ./obj_dir/spi_link_sim | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/spi_link_tb.sv
module spi_link_tb;

    localparam int NUM_XFERS   = 300;
    localparam int XFER_MAX    = (2 * 16 + 1) * 7 + 1;  // 16 bits at divider 6
    localparam int CYCLE_LIMIT = NUM_XFERS * (XFER_MAX + 24) + 200;

    logic                       S_CHAR_GO;
    logic                       S_RESETN;
    logic                       cfg_wr;
    spi_cfg_pkg::reg_addr_e     cfg_addr;
    logic [15:0]                cfg_wdata;
    logic                       sck;
    logic                       mosi;
    logic                       miso;
    logic                       ss_n;
    logic                       busy;
    spi_char_pkg::char_status_t master_status;
    spi_char_pkg::char_status_t slave_status;

    int          errors  = 0;
    int          cycles  = 0;
    int          m_dones = 0;
    int          s_dones = 0;
    logic [15:0] prev_master;  // model of the master rx register

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(2)) clk0 (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN)
    );

    spi_link_top #(.CHAR_NBITS(spi_char_pkg::CHAR_NBITS_DEF)) dut0 (
        .S_CHAR_GO     (S_CHAR_GO),
        .S_RESETN      (S_RESETN),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .sck           (sck),
        .mosi          (mosi),
        .miso          (miso),
        .ss_n          (ss_n),
        .busy          (busy),
        .master_status (master_status),
        .slave_status  (slave_status)
    );

    bind spi_master_engine spi_link_asserts asserts0 (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .busy      (busy),
        .ss_n      (ss_n),
        .sck       (sck),
        .cpol      (cfg.mode.cpol)
    );

    always @(negedge S_CHAR_GO) begin
        if (master_status.done) begin
            m_dones++;
        end
        if (slave_status.done) begin
            s_dones++;
        end
    end

    always @(posedge S_CHAR_GO) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the transfers did not finish", cycles);
            errors++;
            $display("errors: %0d", errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge S_CHAR_GO);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input spi_cfg_pkg::reg_addr_e addr, input logic [15:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
        cfg_wr    = 1'b0;
    endtask

    task automatic run_transfer(input spi_cfg_pkg::spi_mode_t m, input int div,
                                input logic [15:0] mtx, input logic [15:0] stx,
                                input bit second_go);
        int          bits;
        int          eff_div;
        int          lat;
        int          exp_lat;
        int          m_base;
        int          s_base;
        logic [15:0] mask;
        logic [15:0] exp_m;
        bit          m_seen;
        bit          s_seen;
        bits    = int'(m.char_len) + 1;
        mask    = 16'((32'd1 << bits) - 1);
        exp_m   = m.tx_only ? prev_master : (stx & mask);
        eff_div = (div < int'(spi_cfg_pkg::CLK_DIV_MIN)) ? int'(spi_cfg_pkg::CLK_DIV_MIN) : div;
        exp_lat = (2 * bits + 1) * (eff_div + 1) + 1;
        m_base  = m_dones;
        s_base  = s_dones;
        write_reg(spi_cfg_pkg::REG_MODE, {7'd0, m});
        write_reg(spi_cfg_pkg::REG_DIV, 16'(div));
        write_reg(spi_cfg_pkg::REG_MTX, mtx);
        write_reg(spi_cfg_pkg::REG_STX, stx);
        lat    = 0;
        m_seen = 1'b0;
        s_seen = 1'b0;
        while (!(m_seen && s_seen)) begin
            cfg_wr = second_go && (lat == 5);  // extra go lands mid transfer
            step();
            lat++;
            if (lat == 1 && !m.cpha) begin
                // first bit goes out with ss_n
                check_value("mosi", mosi, m.rev ? mtx[m.char_len] : mtx[0]);
            end
            if (master_status.done && !m_seen) begin
                m_seen = 1'b1;
                check_value("go to done latency", lat, exp_lat);
                check_value("master_status.data", master_status.data, exp_m);
            end
            if (slave_status.done && !s_seen) begin
                s_seen = 1'b1;
                check_value("slave_status.data", slave_status.data, mtx & mask);
            end
        end
        cfg_wr      = 1'b0;
        prev_master = exp_m;
        repeat (8) step();
        check_value("master done count", m_dones - m_base, 1);
        check_value("slave done count", s_dones - s_base, 1);
        check_value("busy", busy, 0);
        check_value("ss_n", ss_n, 1);
        check_value("miso", miso, 1);
    endtask

    initial begin
        spi_cfg_pkg::spi_mode_t m;
        int                     div;
        logic [15:0]            mtx;
        logic [15:0]            stx;
        bit                     second_go;
        cfg_wr      = 1'b0;
        cfg_addr    = spi_cfg_pkg::REG_MODE;
        cfg_wdata   = '0;
        prev_master = '0;
        @(posedge S_RESETN);
        step();
        check_value("busy", busy, 0);
        check_value("ss_n", ss_n, 1);
        check_value("sck", sck, 0);
        check_value("miso", miso, 1);
        check_value("master_status.done", master_status.done, 0);
        check_value("slave_status.done", slave_status.done, 0);
        check_value("master_status.data", master_status.data, 0);
        void'($urandom(80));

        m          = '0;
        m.enable   = 1'b1;
        m.rev      = 1'b1;
        m.char_len = 4'd15;
        run_transfer(m, 3, 16'h1234, 16'hc0a5, 1'b0);  // msb first
        m.rev = 1'b0;
        run_transfer(m, 3, 16'h1234, 16'hc0a5, 1'b1);  // lsb first

        for (int i = 0; i < NUM_XFERS; i++) begin
            m.cpol     = 1'($urandom_range(0, 1));
            m.cpha     = 1'($urandom_range(0, 1));
            m.rev      = 1'($urandom_range(0, 1));
            m.tx_only  = ($urandom_range(0, 3) == 0);
            m.char_len = 4'($urandom_range(0, 15));
            div        = $urandom_range(0, 6);
            mtx        = 16'($urandom());
            stx        = 16'($urandom());
            second_go  = ($urandom_range(0, 3) == 0);
            run_transfer(m, div, mtx, stx, second_go);
        end

        check_value("total master dones", m_dones, NUM_XFERS + 2);
        check_value("total slave dones", s_dones, NUM_XFERS + 2);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb/spi_link_asserts.sv
module spi_link_asserts (
    input logic S_CHAR_GO,
    input logic S_RESETN,
    input logic busy,
    input logic ss_n,
    input logic sck,
    input logic cpol
);

    busy_vs_ss_n: assert property (
        @(posedge S_CHAR_GO) disable iff (!S_RESETN) busy == !ss_n
    ) else $error("busy and ss_n are not complementary");

    // sck idles at cpol and is back there when ss_n rises
    sck_idle: assert property (
        @(posedge S_CHAR_GO) disable iff (!S_RESETN)
            ss_n |-> (sck == cpol) && ($past(sck) == $past(cpol))
    ) else $error("sck was away from its idle level while or just before ss_n went high");

    // no sck step when the transfer opens
    sck_start: assert property (
        @(posedge S_CHAR_GO) disable iff (!S_RESETN) $fell(ss_n) |-> (sck == cpol)
    ) else $error("sck was not at its idle level when ss_n fell");

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic S_CHAR_GO,
    output logic S_RESETN
);

    initial begin
        S_CHAR_GO = 1'b0;
        forever #(PERIOD / 2) S_CHAR_GO = ~S_CHAR_GO;
    end

    initial begin
        S_RESETN = 1'b0;
        repeat (RESET_CYCLES) @(posedge S_CHAR_GO);
        #1 S_RESETN = 1'b1;  // release off the edge
    end

endmodule

//--- source/spi_link_top.sv
module spi_link_top #(
    parameter int CHAR_NBITS = spi_char_pkg::CHAR_NBITS_DEF
) (
    input  logic                       S_CHAR_GO,
    input  logic                       S_RESETN,
    input  logic                       cfg_wr,
    input  spi_cfg_pkg::reg_addr_e     cfg_addr,
    input  logic [15:0]                cfg_wdata,
    output logic                       sck,
    output logic                       mosi,
    output logic                       miso,
    output logic                       ss_n,
    output logic                       busy,
    output spi_char_pkg::char_status_t master_status,
    output spi_char_pkg::char_status_t slave_status
);

    spi_cfg_pkg::spi_cfg_t  cfg;
    logic [CHAR_NBITS-1:0]  master_tx;
    logic [CHAR_NBITS-1:0]  slave_tx;
    logic                   go;

    spi_cfg_regs #(
        .CHAR_NBITS(CHAR_NBITS)
    ) regs0 (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg),
        .master_tx (master_tx),
        .slave_tx  (slave_tx),
        .go        (go)
    );

    spi_master_engine #(
        .CHAR_NBITS(CHAR_NBITS)
    ) master0 (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .cfg       (cfg),
        .tx_char   (master_tx),
        .go        (go),
        .miso      (miso),
        .sck       (sck),
        .mosi      (mosi),
        .ss_n      (ss_n),
        .busy      (busy),
        .status    (master_status)
    );

    // slave sees the same mode the registers hold
    spi_slave_engine #(
        .CHAR_NBITS(CHAR_NBITS)
    ) slave0 (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .mode      (cfg.mode),
        .tx_char   (slave_tx),
        .sck       (sck),
        .mosi      (mosi),
        .ss_n      (ss_n),
        .miso      (miso),
        .status    (slave_status)
    );

endmodule

//--- source/spi_slave_engine.sv
module spi_slave_engine #(
    parameter int CHAR_NBITS = spi_char_pkg::CHAR_NBITS_DEF
) (
    input  logic                       S_CHAR_GO,
    input  logic                       S_RESETN,
    input  spi_cfg_pkg::spi_mode_t     mode,
    input  logic [CHAR_NBITS-1:0]      tx_char,
    input  logic                       sck,
    input  logic                       mosi,
    input  logic                       ss_n,
    output logic                       miso,
    output spi_char_pkg::char_status_t status
);

    localparam int IW = $clog2(CHAR_NBITS);
    localparam int SW = spi_char_pkg::CHAR_NBITS_DEF;

    typedef struct packed {
        logic sck;
        logic ss_n;
    } lines_t;

    lines_t                 sync1;
    lines_t                 sync2;
    lines_t                 prev;      // edge reference
    spi_cfg_pkg::spi_mode_t mode_q;
    logic                   active;
    logic [IW-1:0]          idx;
    logic [IW-1:0]          idx_first;
    logic [IW-1:0]          idx_next;
    logic [CHAR_NBITS-1:0]  tx_q;
    logic [CHAR_NBITS-1:0]  rx_sh;
    logic [CHAR_NBITS-1:0]  rx_q;
    logic                   ss_fall;
    logic                   ss_rise;
    logic                   sck_edge;
    logic                   leading;
    logic                   done_q;

    assign ss_fall   = prev.ss_n & ~sync2.ss_n;
    assign ss_rise   = ~prev.ss_n & sync2.ss_n;
    assign sck_edge  = active & (sync2.sck ^ prev.sck);
    assign leading   = sync2.sck ^ mode_q.cpol;         // moving away from idle
    assign idx_first = mode.rev ? IW'(mode.char_len) : '0;
    assign idx_next  = mode_q.rev ? idx - 1'b1 : idx + 1'b1;

    assign status.done = done_q;
    assign status.data = SW'(rx_q);

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sync1  <= '{sck: 1'b0, ss_n: 1'b1};
            sync2  <= '{sck: 1'b0, ss_n: 1'b1};
            prev   <= '{sck: 1'b0, ss_n: 1'b1};
            mode_q <= '0;
            active <= 1'b0;
            miso   <= 1'b1;
            idx    <= '0;
            tx_q   <= '0;
            rx_sh  <= '0;
            rx_q   <= '0;
            done_q <= 1'b0;
        end else begin
            sync1  <= '{sck: sck, ss_n: ss_n};
            sync2  <= sync1;
            prev   <= sync2;
            done_q <= 1'b0;
            if (ss_fall) begin
                active <= 1'b1;
                mode_q <= mode;
                tx_q   <= tx_char;
                rx_sh  <= '0;
                idx    <= idx_first;
                if (!mode.cpha) begin
                    miso <= tx_char[idx_first];  // present before first edge
                end
            end else if (ss_rise && active) begin
                active <= 1'b0;
                miso   <= 1'b1;
                rx_q   <= rx_sh;
                done_q <= 1'b1;
            end else if (sck_edge) begin
                if (leading ^ mode_q.cpha) begin
                    rx_sh[idx] <= mosi;
                end else begin
                    miso <= mode_q.cpha ? tx_q[idx] : tx_q[idx_next];
                end
                if (!leading) begin
                    idx <= idx_next;
                end
            end
        end
    end

endmodule

//--- source/spi_master_engine.sv
module spi_master_engine #(
    parameter int CHAR_NBITS = spi_char_pkg::CHAR_NBITS_DEF
) (
    input  logic                       S_CHAR_GO,
    input  logic                       S_RESETN,
    input  spi_cfg_pkg::spi_cfg_t      cfg,
    input  logic [CHAR_NBITS-1:0]      tx_char,
    input  logic                       go,
    input  logic                       miso,
    output logic                       sck,
    output logic                       mosi,
    output logic                       ss_n,
    output logic                       busy,
    output spi_char_pkg::char_status_t status
);

    localparam int IW = $clog2(CHAR_NBITS);
    localparam int SW = spi_char_pkg::CHAR_NBITS_DEF;

    spi_cfg_pkg::spi_mode_t mode_q;
    logic [7:0]             div_q;
    logic [7:0]             div_cnt;
    logic [5:0]             half_cnt;
    logic [5:0]             half_last;
    logic [IW-1:0]          idx;
    logic [IW-1:0]          idx_first;
    logic [IW-1:0]          idx_next;
    logic [CHAR_NBITS-1:0]  tx_q;
    logic [CHAR_NBITS-1:0]  rx_sh;
    logic [CHAR_NBITS-1:0]  rx_q;
    logic                   sck_q;
    logic                   tick;
    logic                   leading;
    logic                   done_q;

    assign idx_first = cfg.mode.rev ? IW'(cfg.mode.char_len) : '0;
    assign idx_next  = mode_q.rev ? idx - 1'b1 : idx + 1'b1;
    assign tick      = busy && (div_cnt == div_q);
    assign leading   = ~half_cnt[0];                       // odd edges lead
    assign half_last = {1'b0, mode_q.char_len, 1'b0} + 6'd2; // hold after last edge

    // idle level follows the live mode
    assign sck = ss_n ? cfg.mode.cpol : sck_q;

    assign status.done = done_q;
    assign status.data = SW'(rx_q);

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            busy     <= 1'b0;
            ss_n     <= 1'b1;
            sck_q    <= 1'b0;
            mosi     <= 1'b0;
            mode_q   <= '0;
            div_q    <= '0;
            div_cnt  <= '0;
            half_cnt <= '0;
            idx      <= '0;
            tx_q     <= '0;
            rx_sh    <= '0;
            rx_q     <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (go && !busy) begin
                busy     <= 1'b1;
                ss_n     <= 1'b0;
                mode_q   <= cfg.mode;
                div_q    <= cfg.clk_div;
                tx_q     <= tx_char;
                rx_sh    <= '0;
                idx      <= idx_first;
                sck_q    <= cfg.mode.cpol;
                div_cnt  <= '0;
                half_cnt <= '0;
                if (!cfg.mode.cpha) begin
                    mosi <= tx_char[idx_first];  // first bit with ss_n
                end
            end else if (busy) begin
                if (!tick) begin
                    div_cnt <= div_cnt + 1'b1;
                end else begin
                    div_cnt  <= '0;
                    half_cnt <= half_cnt + 1'b1;
                    if (half_cnt == half_last) begin
                        busy   <= 1'b0;
                        ss_n   <= 1'b1;
                        done_q <= 1'b1;
                        if (!mode_q.tx_only) begin
                            rx_q <= rx_sh;
                        end
                    end else begin
                        sck_q <= ~sck_q;
                        if (leading ^ mode_q.cpha) begin
                            rx_sh[idx] <= miso;      // sample edge
                        end else begin
                            mosi <= mode_q.cpha ? tx_q[idx] : tx_q[idx_next];
                        end
                        if (!leading) begin
                            idx <= idx_next;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- source/spi_cfg_regs.sv
module spi_cfg_regs #(
    parameter int CHAR_NBITS = spi_char_pkg::CHAR_NBITS_DEF
) (
    input  logic                   S_CHAR_GO,
    input  logic                   S_RESETN,
    input  logic                   cfg_wr,
    input  spi_cfg_pkg::reg_addr_e cfg_addr,
    input  logic [15:0]            cfg_wdata,
    output spi_cfg_pkg::spi_cfg_t  cfg,
    output logic [CHAR_NBITS-1:0]  master_tx,
    output logic [CHAR_NBITS-1:0]  slave_tx,
    output logic                   go
);

    localparam int MODE_W = $bits(spi_cfg_pkg::spi_mode_t);

    logic       mtx_wr;
    logic       stx_wr;
    logic [7:0] div_wr;

    assign mtx_wr = cfg_wr && (cfg_addr == spi_cfg_pkg::REG_MTX);
    assign stx_wr = cfg_wr && (cfg_addr == spi_cfg_pkg::REG_STX);

    // saturate wide values, raise small ones to the minimum
    assign div_wr = (|cfg_wdata[15:8]) ? 8'hff :
                    (cfg_wdata[7:0] < spi_cfg_pkg::CLK_DIV_MIN) ? spi_cfg_pkg::CLK_DIV_MIN :
                    cfg_wdata[7:0];

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cfg.mode.enable   <= 1'b0;
            cfg.mode.cpol     <= 1'b0;
            cfg.mode.cpha     <= 1'b0;
            cfg.mode.rev      <= 1'b1;                // msb first
            cfg.mode.tx_only  <= 1'b0;
            cfg.mode.char_len <= 4'(CHAR_NBITS - 1);  // full width char
            cfg.clk_div       <= spi_cfg_pkg::CLK_DIV_MIN;
            go                <= 1'b0;
        end else begin
            go <= stx_wr && cfg.mode.enable;          // pulse one cycle after write
            if (cfg_wr) begin
                case (cfg_addr)
                    spi_cfg_pkg::REG_MODE:
                        cfg.mode <= spi_cfg_pkg::spi_mode_t'(cfg_wdata[MODE_W-1:0]);
                    spi_cfg_pkg::REG_DIV:
                        cfg.clk_div <= div_wr;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge S_CHAR_GO) begin
        if (mtx_wr) begin
            master_tx <= cfg_wdata[CHAR_NBITS-1:0];
        end
        if (stx_wr) begin
            slave_tx <= cfg_wdata[CHAR_NBITS-1:0];
        end
    end

endmodule

//--- source/spi_char_pkg.sv
package spi_char_pkg;

    // widest character the link carries
    localparam int CHAR_NBITS_DEF = 16;

    typedef struct packed {
        logic                      done; // one cycle at end of char
        logic [CHAR_NBITS_DEF-1:0] data; // unused high bits are 0
    } char_status_t;

endpackage

//--- source/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // smallest divider the slave synchronizer can follow
    localparam logic [7:0] CLK_DIV_MIN = 8'd3;

    typedef struct packed {
        logic       enable;
        logic       cpol;     // sck idle level
        logic       cpha;     // 1: sample on trailing edge
        logic       rev;      // 1: msb first
        logic       tx_only;  // master keeps old rx data
        logic [3:0] char_len; // bits minus one
    } spi_mode_t;

    typedef struct packed {
        spi_mode_t  mode;
        logic [7:0] clk_div;  // sck half period is clk_div+1 clocks
    } spi_cfg_t;

    typedef enum logic [1:0] {
        REG_MODE,
        REG_DIV,
        REG_MTX,              // master transmit char
        REG_STX               // slave transmit char, starts a transfer
    } reg_addr_e;

endpackage
